/* source/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;

  // major opcodes, instruction bits 30:25
  localparam logic [5:0] TYPE_BASIC = 6'b100000;
  localparam logic [5:0] ADDI       = 6'b101000;
  localparam logic [5:0] ORI        = 6'b101100;
  localparam logic [5:0] XORI       = 6'b101011;
  localparam logic [5:0] LWI        = 6'b000010;
  localparam logic [5:0] SWI        = 6'b001010;
  localparam logic [5:0] MOVI       = 6'b100010;
  localparam logic [5:0] TYPE_LS    = 6'b011100;

  // basic group sub-opcodes, bits 4:0
  localparam logic [4:0] ADD    = 5'b00000;
  localparam logic [4:0] SUB    = 5'b00001;
  localparam logic [4:0] AND_OP = 5'b00010;
  localparam logic [4:0] OR_OP  = 5'b00100;
  localparam logic [4:0] XOR_OP = 5'b00011;
  localparam logic [4:0] SRLI   = 5'b01001;
  localparam logic [4:0] SLLI   = 5'b01000;
  localparam logic [4:0] ROTRI  = 5'b01011;

  // load/store group sub-opcodes, bits 7:0
  localparam logic [7:0] LW = 8'b00000010;
  localparam logic [7:0] SW = 8'b00001010;

  typedef enum logic [3:0] {
    ST_ISSUE    = 4'd0,
    ST_FETCH    = 4'd1,
    ST_EXE      = 4'd2,
    ST_WRITE    = 4'd3,
    ST_LW_FETCH = 4'd4,
    ST_LW_WRITE = 4'd5,
    ST_SW_FETCH = 4'd6,
    ST_SW_WRITE = 4'd7,
    ST_HALT     = 4'd8
  } state_t;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_t;

  typedef enum logic {SRC_REG = 1'b0, SRC_IMM = 1'b1} src_sel_t;

  typedef enum logic {WB_ALU = 1'b0, WB_DMEM = 1'b1} wb_sel_t;

  // host byte addresses
  localparam logic [11:0] IM_BASE   = 12'h000;
  localparam logic [11:0] DM_BASE   = 12'h400;
  localparam logic [11:0] CTRL_ADDR = 12'h800;
  localparam logic [11:0] STAT_ADDR = 12'h804;
  localparam logic [11:0] CNT_ADDR  = 12'h808;

endpackage

/* source/cpu_ctrl_if.sv */
`timescale 1ns/100ps

interface cpu_ctrl_if;
  logic im_en;
  logic dm_en;
  logic dm_we;
  logic reg_read;
  logic alu_exe;
  logic reg_we;
  cpu_pkg::imm_sel_t imm_sel;
  cpu_pkg::src_sel_t src_sel;
  cpu_pkg::wb_sel_t wb_sel;

  // decoded instruction fields
  logic [5:0] opcode;
  logic [4:0] sub5;
  logic [4:0] imm5;
  logic [14:0] imm15;
  logic [19:0] imm20;
  logic [4:0] ra;
  logic [4:0] rb;
  logic [4:0] rt;

  modport ctrl (
    output im_en, dm_en, dm_we, reg_read, alu_exe, reg_we, imm_sel, src_sel, wb_sel,
    output opcode, sub5, imm5, imm15, imm20, ra, rb, rt
  );

  modport dp (
    input im_en, dm_en, dm_we, reg_read, alu_exe, reg_we, imm_sel, src_sel, wb_sel,
    input opcode, sub5, imm5, imm15, imm20, ra, rb, rt
  );
endinterface

/* source/ir_controller.sv */
`timescale 1ns/100ps

module ir_controller (
  input  logic               clock,
  input  logic               reset,
  input  logic               start,
  input  cpu_pkg::word_t     im_rdata,
  cpu_ctrl_if.ctrl           ctl,
  output logic               step,
  output logic               retire,
  output logic               halted
);

  cpu_pkg::state_t state;
  cpu_pkg::state_t state_next;
  cpu_pkg::word_t ir;
  cpu_pkg::word_t cur;
  logic [7:0] sub8;
  logic is_lw;
  logic is_sw;
  logic is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::ST_HALT;
      ir <= '0;
    end else begin
      state <= state_next;
      if (state == cpu_pkg::ST_FETCH) begin
        ir <= im_rdata;
      end
    end
  end

  // during fetch the fields come straight from memory, later from the IR
  assign cur = (state == cpu_pkg::ST_FETCH) ? im_rdata : ir;

  assign ctl.opcode = cur[30:25];
  assign ctl.sub5   = cur[4:0];
  assign ctl.imm5   = cur[14:10];
  assign ctl.imm15  = cur[14:0];
  assign ctl.imm20  = cur[19:0];
  assign ctl.ra     = cur[19:15];
  assign ctl.rb     = cur[14:10];
  assign ctl.rt     = cur[24:20];
  assign sub8 = cur[7:0];

  assign is_lw = (ctl.opcode == cpu_pkg::LWI) ||
                 (ctl.opcode == cpu_pkg::TYPE_LS && sub8 == cpu_pkg::LW);
  assign is_sw = (ctl.opcode == cpu_pkg::SWI) ||
                 (ctl.opcode == cpu_pkg::TYPE_LS && sub8 == cpu_pkg::SW);
  // nop is srli r0,r0,0
  assign is_nop = (ctl.opcode == cpu_pkg::TYPE_BASIC) && (ctl.sub5 == cpu_pkg::SRLI) &&
                  (ctl.imm5 == 5'd0) && (ctl.rt == 5'd0) && (ctl.ra == 5'd0);

  always_comb begin
    state_next = state;
    ctl.im_en = 1'b0;
    ctl.dm_en = 1'b0;
    ctl.dm_we = 1'b0;
    ctl.reg_read = 1'b0;
    ctl.alu_exe = 1'b0;
    ctl.reg_we = 1'b0;
    case (state)
      cpu_pkg::ST_HALT: begin
        if (start) begin
          state_next = cpu_pkg::ST_ISSUE;
        end
      end
      cpu_pkg::ST_ISSUE: begin
        ctl.im_en = 1'b1;
        state_next = cpu_pkg::ST_FETCH;
      end
      cpu_pkg::ST_FETCH: begin
        if (im_rdata == '0) begin
          state_next = cpu_pkg::ST_HALT;
        end else begin
          ctl.reg_read = 1'b1;
          state_next = cpu_pkg::ST_EXE;
        end
      end
      cpu_pkg::ST_EXE: begin
        ctl.alu_exe = 1'b1;
        state_next = cpu_pkg::ST_LW_FETCH;
      end
      cpu_pkg::ST_LW_FETCH: begin
        ctl.dm_en = is_lw;
        state_next = cpu_pkg::ST_LW_WRITE;
      end
      cpu_pkg::ST_LW_WRITE: begin
        state_next = cpu_pkg::ST_WRITE;
      end
      cpu_pkg::ST_WRITE: begin
        ctl.reg_we = !(is_nop || is_sw);
        state_next = cpu_pkg::ST_SW_FETCH;
      end
      cpu_pkg::ST_SW_FETCH: begin
        // store data comes from rt
        ctl.reg_read = is_sw;
        state_next = cpu_pkg::ST_SW_WRITE;
      end
      cpu_pkg::ST_SW_WRITE: begin
        ctl.dm_en = is_sw;
        ctl.dm_we = is_sw;
        state_next = cpu_pkg::ST_ISSUE;
      end
      default: begin
        state_next = cpu_pkg::ST_HALT;
      end
    endcase
  end

  always_comb begin
    ctl.imm_sel = cpu_pkg::IMM5_ZE;
    ctl.src_sel = cpu_pkg::SRC_REG;
    case (ctl.opcode)
      cpu_pkg::TYPE_BASIC: begin
        if (ctl.sub5 == cpu_pkg::SRLI || ctl.sub5 == cpu_pkg::SLLI ||
            ctl.sub5 == cpu_pkg::ROTRI) begin
          ctl.src_sel = cpu_pkg::SRC_IMM;
        end
      end
      cpu_pkg::ADDI: begin
        ctl.imm_sel = cpu_pkg::IMM15_SE;
        ctl.src_sel = cpu_pkg::SRC_IMM;
      end
      cpu_pkg::ORI, cpu_pkg::XORI, cpu_pkg::LWI, cpu_pkg::SWI: begin
        ctl.imm_sel = cpu_pkg::IMM15_ZE;
        ctl.src_sel = cpu_pkg::SRC_IMM;
      end
      cpu_pkg::MOVI: begin
        ctl.imm_sel = cpu_pkg::IMM20_SE;
        ctl.src_sel = cpu_pkg::SRC_IMM;
      end
      default: begin
        ctl.imm_sel = cpu_pkg::IMM5_ZE;
      end
    endcase
  end

  assign ctl.wb_sel = is_lw ? cpu_pkg::WB_DMEM : cpu_pkg::WB_ALU;

  assign step   = (state == cpu_pkg::ST_WRITE);
  assign retire = (state == cpu_pkg::ST_WRITE);
  assign halted = (state == cpu_pkg::ST_HALT);

endmodule

/* source/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit #(
  parameter int IM_ADDR_BITS = 8
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    step,
  input  logic                    retire,
  output logic [IM_ADDR_BITS-1:0] pc,
  output cpu_pkg::word_t          count
);

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
      count <= '0;
    end else if (start) begin
      // a new run begins at word zero
      pc <= '0;
      count <= '0;
    end else begin
      if (step) begin
        pc <= pc + 1'b1;
      end
      if (retire) begin
        count <= count + 32'd1;
      end
    end
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic           clock,
  input  logic           reset,
  cpu_ctrl_if.dp         ctl,
  input  cpu_pkg::word_t wdata,
  output cpu_pkg::word_t rdata_a,
  output cpu_pkg::word_t rdata_b
);

  cpu_pkg::word_t regs [0:31];
  logic exe_seen;
  logic [4:0] addr_b;

  // a read after the execute step is the store-data read of rt
  assign addr_b = exe_seen ? ctl.rt : ctl.rb;

  always_ff @(posedge clock) begin
    if (reset) begin
      exe_seen <= 1'b0;
    end else if (ctl.im_en) begin
      exe_seen <= 1'b0;
    end else if (ctl.alu_exe) begin
      exe_seen <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      rdata_a <= '0;
      rdata_b <= '0;
    end else begin
      if (ctl.reg_read) begin
        rdata_a <= regs[ctl.ra];
        rdata_b <= regs[addr_b];
      end
      if (ctl.reg_we) begin
        regs[ctl.rt] <= wdata;
      end
    end
  end

endmodule

/* source/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
  input  logic           clock,
  input  logic           reset,
  cpu_ctrl_if.dp         ctl,
  input  cpu_pkg::word_t rdata_a,
  input  cpu_pkg::word_t rdata_b,
  input  cpu_pkg::word_t dm_rdata,
  output cpu_pkg::word_t result,
  output cpu_pkg::word_t wdata
);

  cpu_pkg::word_t imm_ext;
  cpu_pkg::word_t op_b;
  cpu_pkg::word_t alu_out;
  logic [63:0] rot;
  logic [4:0] sh;

  always_comb begin
    case (ctl.imm_sel)
      cpu_pkg::IMM15_SE: imm_ext = {{17{ctl.imm15[14]}}, ctl.imm15};
      cpu_pkg::IMM15_ZE: imm_ext = {17'd0, ctl.imm15};
      cpu_pkg::IMM20_SE: imm_ext = {{12{ctl.imm20[19]}}, ctl.imm20};
      default:           imm_ext = {27'd0, ctl.imm5};
    endcase
  end

  assign op_b = (ctl.src_sel == cpu_pkg::SRC_IMM) ? imm_ext : rdata_b;
  assign sh = op_b[4:0];
  assign rot = {rdata_a, rdata_a} >> sh;

  always_comb begin
    case (ctl.opcode)
      cpu_pkg::TYPE_BASIC: begin
        case (ctl.sub5)
          cpu_pkg::ADD:    alu_out = rdata_a + op_b;
          cpu_pkg::SUB:    alu_out = rdata_a - op_b;
          cpu_pkg::AND_OP: alu_out = rdata_a & op_b;
          cpu_pkg::OR_OP:  alu_out = rdata_a | op_b;
          cpu_pkg::XOR_OP: alu_out = rdata_a ^ op_b;
          cpu_pkg::SRLI:   alu_out = rdata_a >> sh;
          cpu_pkg::SLLI:   alu_out = rdata_a << sh;
          cpu_pkg::ROTRI:  alu_out = rot[31:0];
          default:         alu_out = rdata_a;
        endcase
      end
      cpu_pkg::ORI:  alu_out = rdata_a | op_b;
      cpu_pkg::XORI: alu_out = rdata_a ^ op_b;
      cpu_pkg::MOVI: alu_out = op_b;
      // addi and every load/store address
      default:       alu_out = rdata_a + op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (ctl.alu_exe) begin
      result <= alu_out;
    end
  end

  assign wdata = (ctl.wb_sel == cpu_pkg::WB_DMEM) ? dm_rdata : result;

endmodule

/* source/sync_mem.sv */
`timescale 1ns/100ps

module sync_mem #(
  parameter int ADDR_BITS = 8
) (
  input  logic                 clock,
  input  logic                 en,
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] addr,
  input  cpu_pkg::word_t       wdata,
  output cpu_pkg::word_t       rdata
);

  cpu_pkg::word_t mem [0:2**ADDR_BITS-1];

  // read data holds until the next enabled access
  always_ff @(posedge clock) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
  parameter int IM_ADDR_BITS = 8,
  parameter int DM_ADDR_BITS = 8
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  logic [11:0]    paddr,
  input  cpu_pkg::word_t pwdata,
  output cpu_pkg::word_t prdata,
  output logic           pready
);

  cpu_ctrl_if ctl ();

  logic setup_rd;
  logic access_wr;
  logic im_host;
  logic dm_host;
  logic start;
  logic step;
  logic retire;
  logic halted;
  logic rd_im;
  logic rd_dm;
  logic im_en;
  logic im_we;
  logic dm_en;
  logic dm_we;
  logic [IM_ADDR_BITS-1:0] pc;
  logic [IM_ADDR_BITS-1:0] im_addr;
  logic [DM_ADDR_BITS-1:0] dm_addr;
  cpu_pkg::word_t count;
  cpu_pkg::word_t im_rdata;
  cpu_pkg::word_t dm_rdata;
  cpu_pkg::word_t dm_wdata;
  cpu_pkg::word_t rdata_a;
  cpu_pkg::word_t rdata_b;
  cpu_pkg::word_t result;
  cpu_pkg::word_t wdata;
  cpu_pkg::word_t reg_rdata;

  assign setup_rd  = psel && !penable && !pwrite;
  assign access_wr = psel && penable && pwrite;
  assign im_host   = (paddr[11:10] == cpu_pkg::IM_BASE[11:10]);
  assign dm_host   = (paddr[11:10] == cpu_pkg::DM_BASE[11:10]);
  assign start     = access_wr && (paddr == cpu_pkg::CTRL_ADDR) && pwdata[0] && halted;

  // host owns both memories only while halted
  assign im_en   = halted ? (im_host && (setup_rd || access_wr)) : ctl.im_en;
  assign im_we   = halted && im_host && access_wr;
  assign im_addr = halted ? paddr[IM_ADDR_BITS+1:2] : pc;
  assign dm_en   = halted ? (dm_host && (setup_rd || access_wr)) : ctl.dm_en;
  assign dm_we   = halted ? (dm_host && access_wr) : ctl.dm_we;
  assign dm_addr = halted ? paddr[DM_ADDR_BITS+1:2] : result[DM_ADDR_BITS-1:0];
  assign dm_wdata = halted ? pwdata : rdata_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      pready <= 1'b0;
      rd_im <= 1'b0;
      rd_dm <= 1'b0;
      reg_rdata <= '0;
    end else begin
      pready <= psel && !penable;
      if (setup_rd) begin
        rd_im <= halted && im_host;
        rd_dm <= halted && dm_host;
        case (paddr)
          cpu_pkg::STAT_ADDR: reg_rdata <= {31'd0, halted};
          cpu_pkg::CNT_ADDR:  reg_rdata <= count;
          default:            reg_rdata <= '0;
        endcase
      end
    end
  end

  assign prdata = rd_im ? im_rdata : (rd_dm ? dm_rdata : reg_rdata);

  ir_controller i_ir_controller (
    .clock(clock), .reset(reset), .start(start), .im_rdata(im_rdata),
    .ctl(ctl.ctrl), .step(step), .retire(retire), .halted(halted)
  );

  pc_unit #(.IM_ADDR_BITS(IM_ADDR_BITS)) i_pc_unit (
    .clock(clock), .reset(reset), .start(start), .step(step), .retire(retire),
    .pc(pc), .count(count)
  );

  reg_file i_reg_file (
    .clock(clock), .reset(reset), .ctl(ctl.dp), .wdata(wdata),
    .rdata_a(rdata_a), .rdata_b(rdata_b)
  );

  exec_unit i_exec_unit (
    .clock(clock), .reset(reset), .ctl(ctl.dp), .rdata_a(rdata_a), .rdata_b(rdata_b),
    .dm_rdata(dm_rdata), .result(result), .wdata(wdata)
  );

  sync_mem #(.ADDR_BITS(IM_ADDR_BITS)) i_imem (
    .clock(clock), .en(im_en), .we(im_we), .addr(im_addr), .wdata(pwdata),
    .rdata(im_rdata)
  );

  sync_mem #(.ADDR_BITS(DM_ADDR_BITS)) i_dmem (
    .clock(clock), .en(dm_en), .we(dm_we), .addr(dm_addr), .wdata(dm_wdata),
    .rdata(dm_rdata)
  );

endmodule

/* tests/cpu_chk.sv */
`timescale 1ns/100ps

module cpu_chk (
  input logic clock,
  input logic reset,
  input logic start,
  input logic im_en,
  input logic dm_en,
  input logic dm_we,
  input logic reg_read,
  input logic alu_exe,
  input logic reg_we,
  input logic psel,
  input logic penable,
  input logic pready
);

  logic started;
  int we_fails = 0;
  int overlap_fails = 0;
  int ready_fails = 0;
  int idle_fails = 0;

  always_ff @(posedge clock) begin
    if (reset) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  // store write follows the store-data read
  assert property (@(posedge clock) disable iff (reset)
                   dm_we |-> (dm_en && $past(reg_read)))
    else begin
      we_fails++;
      $error("dm_we without dm_en or without the store-data read before it");
    end

  // write-back comes three steps after execute
  assert property (@(posedge clock) disable iff (reset)
                   reg_we |-> (!alu_exe && $past(alu_exe, 3)))
    else begin
      overlap_fails++;
      $error("reg_we with alu_exe or not three cycles after alu_exe");
    end

  // pready belongs to the access phase only
  assert property (@(posedge clock) disable iff (reset) pready |-> (psel && penable))
    else begin
      ready_fails++;
      $error("pready outside the access phase");
    end

  assert property (@(posedge clock) disable iff (reset)
                   !started |-> !(im_en || dm_en || reg_read || alu_exe || reg_we))
    else begin
      idle_fails++;
      $error("core enable active before the first start");
    end

endmodule

bind cpu_top cpu_chk i_cpu_chk (
  .clock(clock), .reset(reset), .start(start),
  .im_en(ctl.im_en), .dm_en(ctl.dm_en), .dm_we(ctl.dm_we), .reg_read(ctl.reg_read),
  .alu_exe(ctl.alu_exe), .reg_we(ctl.reg_we),
  .psel(psel), .penable(penable), .pready(pready)
);

/* tests/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

  localparam int DM_WORDS = 256;
  localparam int DM_ADDR_BITS = 8;

  logic clock;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [11:0] paddr;
  cpu_pkg::word_t pwdata;
  cpu_pkg::word_t prdata;
  logic pready;

  cpu_pkg::word_t m_reg [0:31];
  cpu_pkg::word_t m_dm [0:DM_WORDS-1];
  cpu_pkg::word_t prog [$];
  integer seed;
  int errors;
  int tests;
  int failed;
  int test_errors;
  bit timed_out;

  cpu_top i_cpu_top (
    .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
  );

  always #2 clock = ~clock;

  function automatic logic [11:0] word_addr(input logic [11:0] base, input int idx);
    return base + {idx[9:0], 2'b00};
  endfunction

  function automatic cpu_pkg::word_t rand_word();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rand_small();
    cpu_pkg::word_t r;
    r = $random(seed);
    return r[4:0];
  endfunction

  function automatic logic [4:0] rand_src();
    cpu_pkg::word_t r;
    r = $random(seed);
    return {1'b0, r[3:0]};
  endfunction

  // r0 is never a destination, so it stays zero as a store base
  function automatic logic [4:0] rand_dest();
    cpu_pkg::word_t r;
    r = $random(seed);
    if (r[3:0] == 4'd0) begin
      return 5'd1;
    end
    return {1'b0, r[3:0]};
  endfunction

  function automatic logic [4:0] rand_base();
    cpu_pkg::word_t r;
    r = $random(seed);
    return {3'd0, r[1:0]} + 5'd1;
  endfunction

  function automatic logic [4:0] rand_load_dest();
    cpu_pkg::word_t r;
    logic [3:0] t;
    r = $random(seed);
    t = r[3:0];
    if (t < 4'd5) begin
      t = t + 4'd5;
    end
    return {1'b0, t};
  endfunction

  function automatic cpu_pkg::word_t basic_op(input logic [4:0] sub, input logic [4:0] rt,
                                               input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::TYPE_BASIC, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic cpu_pkg::word_t imm_op(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic cpu_pkg::word_t movi_op(input logic [4:0] rt, input logic [19:0] imm);
    return {1'b0, cpu_pkg::MOVI, rt, imm};
  endfunction

  function automatic cpu_pkg::word_t ls_op(input logic [7:0] sub, input logic [4:0] rt,
                                            input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::TYPE_LS, rt, ra, rb, 2'b00, sub};
  endfunction

  function automatic cpu_pkg::word_t rand_alu();
    cpu_pkg::word_t r;
    cpu_pkg::word_t w;
    r = $random(seed);
    case (r[3:0])
      4'd0: w = basic_op(cpu_pkg::ADD, rand_dest(), rand_src(), rand_src());
      4'd1: w = basic_op(cpu_pkg::SUB, rand_dest(), rand_src(), rand_src());
      4'd2: w = basic_op(cpu_pkg::AND_OP, rand_dest(), rand_src(), rand_src());
      4'd3: w = basic_op(cpu_pkg::OR_OP, rand_dest(), rand_src(), rand_src());
      4'd4: w = basic_op(cpu_pkg::XOR_OP, rand_dest(), rand_src(), rand_src());
      4'd5: w = basic_op(cpu_pkg::SRLI, rand_dest(), rand_src(), rand_small());
      4'd6: w = basic_op(cpu_pkg::SLLI, rand_dest(), rand_src(), rand_small());
      4'd7: w = basic_op(cpu_pkg::ROTRI, rand_dest(), rand_src(), rand_small());
      4'd8, 4'd9: w = imm_op(cpu_pkg::ADDI, rand_dest(), rand_src(), r[18:4]);
      4'd10: w = imm_op(cpu_pkg::ORI, rand_dest(), rand_src(), r[18:4]);
      4'd11: w = imm_op(cpu_pkg::XORI, rand_dest(), rand_src(), r[18:4]);
      default: w = movi_op(rand_dest(), r[23:4]);
    endcase
    return w;
  endfunction

  // reference model, one instruction
  task automatic model_step(input cpu_pkg::word_t w);
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t ze15;
    cpu_pkg::word_t addr;
    rt = w[24:20];
    ra = w[19:15];
    rb = w[14:10];
    a = m_reg[ra];
    b = m_reg[rb];
    ze15 = {17'd0, w[14:0]};
    case (w[30:25])
      cpu_pkg::TYPE_BASIC: begin
        case (w[4:0])
          cpu_pkg::ADD:    m_reg[rt] = a + b;
          cpu_pkg::SUB:    m_reg[rt] = a - b;
          cpu_pkg::AND_OP: m_reg[rt] = a & b;
          cpu_pkg::OR_OP:  m_reg[rt] = a | b;
          cpu_pkg::XOR_OP: m_reg[rt] = a ^ b;
          cpu_pkg::SLLI:   m_reg[rt] = a << rb;
          cpu_pkg::ROTRI:  m_reg[rt] = (a >> rb) | (a << (6'd32 - {1'b0, rb}));
          // nop leaves r0 as it was
          cpu_pkg::SRLI:   m_reg[rt] = a >> rb;
          default: begin
          end
        endcase
      end
      cpu_pkg::ADDI: m_reg[rt] = a + {{17{w[14]}}, w[14:0]};
      cpu_pkg::ORI:  m_reg[rt] = a | ze15;
      cpu_pkg::XORI: m_reg[rt] = a ^ ze15;
      cpu_pkg::MOVI: m_reg[rt] = {{12{w[19]}}, w[19:0]};
      cpu_pkg::LWI: begin
        addr = a + ze15;
        m_reg[rt] = m_dm[addr[DM_ADDR_BITS-1:0]];
      end
      cpu_pkg::SWI: begin
        addr = a + ze15;
        m_dm[addr[DM_ADDR_BITS-1:0]] = m_reg[rt];
      end
      cpu_pkg::TYPE_LS: begin
        addr = a + b;
        if (w[7:0] == cpu_pkg::LW) begin
          m_reg[rt] = m_dm[addr[DM_ADDR_BITS-1:0]];
        end else if (w[7:0] == cpu_pkg::SW) begin
          m_dm[addr[DM_ADDR_BITS-1:0]] = m_reg[rt];
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic model_run(output int n);
    n = 0;
    for (int i = 0; i < prog.size(); i++) begin
      if (prog[i] == 32'd0) begin
        break;
      end
      model_step(prog[i]);
      n++;
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input cpu_pkg::word_t data);
    @(posedge clock);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clock);
    #1;
    penable = 1'b1;
    if (pready !== 1'b1) begin
      errors++;
      $display("Error at %0t: pready low in write access to %h", $time, addr);
    end
    @(posedge clock);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output cpu_pkg::word_t data);
    @(posedge clock);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clock);
    #1;
    penable = 1'b1;
    if (pready !== 1'b1) begin
      errors++;
      $display("Error at %0t: pready low in read access to %h", $time, addr);
    end
    data = prdata;
    @(posedge clock);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      apb_write(word_addr(cpu_pkg::IM_BASE, i), prog[i]);
    end
  endtask

  // one status read per loop pass, three cycles each
  task automatic wait_halt(input int limit);
    cpu_pkg::word_t st;
    int cycles;
    cycles = 0;
    st = '0;
    while (st[0] !== 1'b1 && !timed_out) begin
      if (cycles > limit) begin
        timed_out = 1'b1;
        errors++;
        $display("the halt flag did not rise within %0d cycles", limit);
      end else begin
        apb_read(cpu_pkg::STAT_ADDR, st);
        cycles += 3;
      end
    end
  endtask

  task automatic check_count(input int expected);
    cpu_pkg::word_t got;
    apb_read(cpu_pkg::CNT_ADDR, got);
    if (got !== expected) begin
      errors++;
      $display("Error at %0t: count read %0d, expected %0d", $time, got, expected);
    end
  endtask

  task automatic check_dm();
    cpu_pkg::word_t got;
    for (int i = 0; i < DM_WORDS; i++) begin
      apb_read(word_addr(cpu_pkg::DM_BASE, i), got);
      if (got !== m_dm[i]) begin
        errors++;
        $display("Error at %0t: dm[%0d] read %h, expected %h", $time, i, got, m_dm[i]);
      end
    end
  endtask

  // SWI of r0..r15 to words block*16 + r
  task automatic push_store_back(input logic [3:0] block);
    for (int r = 0; r < 16; r++) begin
      prog.push_back(imm_op(cpu_pkg::SWI, r[4:0], 5'd0, {7'd0, block, r[3:0]}));
    end
  endtask

  task automatic run_and_check();
    int exp_count;
    model_run(exp_count);
    load_program();
    apb_write(cpu_pkg::CTRL_ADDR, 32'd1);
    wait_halt(8 * prog.size() + 10);
    if (!timed_out) begin
      check_count(exp_count);
      check_dm();
    end
  endtask

  task automatic test_host_dm();
    cpu_pkg::word_t got;
    apb_read(cpu_pkg::STAT_ADDR, got);
    if (got !== 32'd1) begin
      errors++;
      $display("Error at %0t: status after reset read %h, expected 1", $time, got);
    end
    check_count(0);
    for (int i = 0; i < DM_WORDS; i++) begin
      m_dm[i] = rand_word();
      apb_write(word_addr(cpu_pkg::DM_BASE, i), m_dm[i]);
    end
    check_dm();
  endtask

  task automatic test_alu();
    prog.delete();
    repeat (20) begin
      prog.push_back(rand_alu());
    end
    push_store_back(4'd8);
    prog.push_back(32'd0);
    run_and_check();
  endtask

  task automatic test_load_store();
    cpu_pkg::word_t r;
    prog.delete();
    // small bases in r1..r4 keep every address in range
    for (int b = 1; b < 5; b++) begin
      prog.push_back(movi_op(b[4:0], {15'd0, rand_small()}));
    end
    repeat (20) begin
      r = rand_word();
      case (r[1:0])
        2'd0: prog.push_back(imm_op(cpu_pkg::LWI, rand_load_dest(), rand_base(),
                                    {10'd0, rand_small()}));
        2'd1: prog.push_back(ls_op(cpu_pkg::LW, rand_load_dest(), rand_base(), rand_base()));
        2'd2: prog.push_back(ls_op(cpu_pkg::SW, rand_src(), rand_base(), rand_base()));
        default: prog.push_back(imm_op(cpu_pkg::SWI, rand_src(), rand_base(),
                                       {10'd0, rand_small()}));
      endcase
    end
    push_store_back(4'd4);
    prog.push_back(32'd0);
    run_and_check();
  endtask

  task automatic test_nop();
    cpu_pkg::word_t v;
    prog.delete();
    for (int r = 1; r < 16; r++) begin
      v = rand_word();
      prog.push_back(movi_op(r[4:0], v[19:0]));
      if (r % 4 == 0) begin
        prog.push_back(basic_op(cpu_pkg::SRLI, 5'd0, 5'd0, 5'd0));
      end
    end
    prog.push_back(basic_op(cpu_pkg::SRLI, 5'd0, 5'd0, 5'd0));
    prog.push_back(basic_op(cpu_pkg::SRLI, 5'd0, 5'd0, 5'd0));
    // shift by zero into another register is a copy, not a nop
    prog.push_back(basic_op(cpu_pkg::SRLI, 5'd15, 5'd3, 5'd0));
    push_store_back(4'd10);
    prog.push_back(32'd0);
    run_and_check();
  endtask

  task automatic test_running();
    cpu_pkg::word_t got;
    cpu_pkg::word_t im_probe;
    int exp_count;
    im_probe = rand_word();
    apb_write(word_addr(cpu_pkg::IM_BASE, 250), im_probe);
    prog.delete();
    repeat (20) begin
      prog.push_back(rand_alu());
    end
    push_store_back(4'd12);
    prog.push_back(32'd0);
    model_run(exp_count);
    load_program();
    apb_write(cpu_pkg::CTRL_ADDR, 32'd1);
    // core owns both memories now
    apb_read(word_addr(cpu_pkg::DM_BASE, 255), got);
    if (got !== 32'd0) begin
      errors++;
      $display("Error at %0t: dm read while running gave %h, expected 0", $time, got);
    end
    apb_read(word_addr(cpu_pkg::IM_BASE, 250), got);
    if (got !== 32'd0) begin
      errors++;
      $display("Error at %0t: im read while running gave %h, expected 0", $time, got);
    end
    apb_write(word_addr(cpu_pkg::DM_BASE, 255), ~m_dm[255]);
    apb_write(word_addr(cpu_pkg::IM_BASE, 250), ~im_probe);
    wait_halt(8 * prog.size() + 10);
    if (timed_out) begin
      return;
    end
    check_count(exp_count);
    check_dm();
    apb_read(word_addr(cpu_pkg::IM_BASE, 250), got);
    if (got !== im_probe) begin
      errors++;
      $display("Error at %0t: im[250] read %h, expected %h", $time, got, im_probe);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == test_errors) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    seed = 32'hd70b5f60;
    errors = 0;
    tests = 0;
    failed = 0;
    test_errors = 0;
    timed_out = 1'b0;
    clock = 1'b0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    for (int i = 0; i < 32; i++) begin
      m_reg[i] = '0;
    end
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    test_host_dm();
    report_test("host data memory access");
    if (!timed_out) begin
      test_alu();
      report_test("random alu program");
    end
    if (!timed_out) begin
      test_load_store();
      report_test("load and store");
    end
    if (!timed_out) begin
      test_nop();
      report_test("nop");
    end
    if (!timed_out) begin
      test_running();
      report_test("host access while running");
    end

    errors += i_cpu_top.i_cpu_chk.we_fails + i_cpu_top.i_cpu_chk.overlap_fails +
              i_cpu_top.i_cpu_chk.ready_fails + i_cpu_top.i_cpu_chk.idle_fails;
    $display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/cpu_pkg.sv
source/cpu_ctrl_if.sv
source/ir_controller.sv
source/pc_unit.sv
source/reg_file.sv
source/exec_unit.sv
source/sync_mem.sv
source/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

/* Makefile */
# Verilator build and run of the cpu testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f filelist.f
	./obj_dir/Vcpu_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
